// File: scurve_cfg.svh
`ifndef SCURVE_CFG_SVH
`define SCURVE_CFG_SVH

//////////////////////////////////////////////////////////////
// Sweep and measurement lengths
//////////////////////////////////////////////////////////////
`define SCURVE_LAST_DAC 3      // Hardware sweeps up to 1023
`define SCURVE_PULSES 6        // Injections per DAC step
`define SCURVE_LISTEN 4        // Trigger window after each injection

// Settling after the slow-control loader reports done
`define SCURVE_LOAD_DELAY 20   // Hardware uses 2800

`define SCURVE_FIFO_DEPTH 8

// Stream markers, ASCII "SC" and end of run
`define SCURVE_HEADER 16'h5343
`define SCURVE_TRAILER 16'hFF45

`endif

// File: scurvePkg.sv
package scurvePkg;

  //////////////////////////////////////////////////////////////
  // Run and slow-control records
  //////////////////////////////////////////////////////////////
  typedef struct packed {
    logic singleChn;       // High for one channel only
    logic [5:0] testChn;   // Channel of a single-channel run
    logic ctestSel;        // High: CTest pin, low: input pin
  } runConfigT;

  typedef struct packed {
    logic [63:0] ctestChn;     // One-hot CTest select
    logic [9:0] dac10;         // LSB first as the ASIC shifts it in
    logic [191:0] discriMask;  // Three discriminators per channel
  } scParamsT;

  //////////////////////////////////////////////////////////////
  // State machines
  //////////////////////////////////////////////////////////////
  typedef enum logic [4:0] {
    ctrlIdle,
    ctrlHeader,
    ctrlSetChannel,
    ctrlWriteChannel,
    ctrlSetDac,
    ctrlWriteDac,
    ctrlLoad,
    ctrlWaitLoad,
    ctrlStartTest,
    ctrlWaitTest,
    ctrlWaitData,
    ctrlGetData,
    ctrlPutData,
    ctrlNextDac,
    ctrlNextChannel,
    ctrlTrailer,
    ctrlDone
  } ctrlStateT;

  typedef enum logic [1:0] {cntIdle, cntInject, cntListen, cntHold} counterStateT;

endpackage

// File: triggerCounter.sv
`timescale 1ns/1ns
`include "scurve_cfg.svh"

module triggerCounter (
  input  logic        Clk,
  input  logic        reset_n,
  input  logic        MeasureStart,
  input  logic        Trigger,
  input  logic        CountRdEn,
  output logic        Inject,
  output logic        MeasureDone,
  output logic        CountEmpty,
  output logic [15:0] CountWord
);
  import scurvePkg::*;

  localparam int HitW = $clog2(`SCURVE_PULSES + 1);
  localparam int PulseW = $clog2(`SCURVE_PULSES + 1);
  localparam int ListenW = $clog2(`SCURVE_LISTEN + 1);

  counterStateT state;
  logic [PulseW-1:0] pulseCnt;
  logic [ListenW-1:0] listenCnt;
  logic [HitW-1:0] hitCnt;
  logic [HitW-1:0] hitNext;
  logic hitSeen;   // One hit per window at most
  logic hitNow;
  logic lastCycle;
  logic [15:0] countHold;

  assign hitNow = (state == cntListen) && Trigger && !hitSeen;
  assign hitNext = hitCnt + HitW'(hitNow);
  assign lastCycle = (state == cntListen) && (listenCnt == ListenW'(`SCURVE_LISTEN - 1)) &&
                     (pulseCnt == PulseW'(`SCURVE_PULSES - 1));

  assign Inject = (state == cntInject);
  assign MeasureDone = (state == cntHold);   // Single cycle, hold lasts one clock
  assign CountWord = countHold;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= cntIdle;
      pulseCnt <= '0;
      listenCnt <= '0;
      hitCnt <= '0;
      hitSeen <= 1'b0;
    end else begin
      case (state)
        cntIdle: begin
          pulseCnt <= '0;
          hitCnt <= '0;
          if (MeasureStart) state <= cntInject;
        end
        cntInject: begin
          listenCnt <= '0;
          hitSeen <= 1'b0;
          state <= cntListen;
        end
        cntListen: begin
          hitCnt <= hitNext;
          if (hitNow) hitSeen <= 1'b1;
          if (listenCnt == ListenW'(`SCURVE_LISTEN - 1)) begin
            if (lastCycle) begin
              state <= cntHold;
            end else begin
              pulseCnt <= pulseCnt + 1'b1;
              state <= cntInject;   // Next injection
            end
          end else begin
            listenCnt <= listenCnt + 1'b1;
          end
        end
        default: state <= cntIdle;   // cntHold
      endcase
    end
  end

  // One-word hold toward the controller
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) CountEmpty <= 1'b1;
    else if (lastCycle) CountEmpty <= 1'b0;
    else if (CountRdEn) CountEmpty <= 1'b1;
  end

  always_ff @(posedge Clk) begin
    if (lastCycle) countHold <= 16'(hitNext);
  end

endmodule

// File: scurveTestControl.sv
`timescale 1ns/1ns
`include "scurve_cfg.svh"

module scurveTestControl (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 TestStart,
  input  scurvePkg::runConfigT RunConfig,
  input  logic                 ConfigDone,
  input  logic                 MeasureDone,
  input  logic                 CountEmpty,
  input  logic                 UsbFull,
  input  logic                 TransmitDone,
  input  logic [15:0]          CountWord,
  output scurvePkg::scParamsT  ScParams,
  output logic                 ScParamLoad,
  output logic                 MeasureStart,
  output logic                 CountRdEn,
  output logic                 UsbWrEn,
  output logic                 TestDone,
  output logic [15:0]          UsbDin
);
  import scurvePkg::*;

  localparam int LoadW = $clog2(`SCURVE_LOAD_DELAY + 1);
  localparam logic [191:0] MaskTop = {3'b111, 189'b0};   // Channel 0 sits at the top

  ctrlStateT state;
  logic singleRun;
  logic ctestRun;
  logic [5:0] chnCnt;
  logic [9:0] dacCode;
  logic [LoadW-1:0] loadCnt;
  logic [7:0] maskShift;

  assign maskShift = 8'(chnCnt) * 8'd3;

  // The ASIC takes the DAC code LSB first
  function automatic logic [9:0] reverseBits(input logic [9:0] code);
    logic [9:0] rev;
    for (int i = 0; i < 10; i++) begin
      rev[i] = code[9 - i];
    end
    return rev;
  endfunction

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= ctrlIdle;
      singleRun <= 1'b0;
      ctestRun <= 1'b0;
      chnCnt <= '0;
      dacCode <= '0;
      loadCnt <= '0;
      ScParams.ctestChn <= '0;
      ScParams.dac10 <= '0;
      ScParams.discriMask <= '1;
      ScParamLoad <= 1'b0;
      MeasureStart <= 1'b0;
      CountRdEn <= 1'b0;
      UsbWrEn <= 1'b0;
      TestDone <= 1'b0;
      UsbDin <= '0;
    end else begin
      case (state)
        ////////////////////////////////////////////////////////////
        // Run setup
        ////////////////////////////////////////////////////////////
        ctrlIdle: begin
          ScParams.ctestChn <= '0;
          ScParams.dac10 <= '0;
          ScParams.discriMask <= '1;   // All discriminators masked
          dacCode <= '0;
          loadCnt <= '0;
          UsbWrEn <= 1'b0;
          if (TestStart) begin
            singleRun <= RunConfig.singleChn;
            ctestRun <= RunConfig.ctestSel;
            chnCnt <= RunConfig.singleChn ? RunConfig.testChn : 6'd0;
            UsbDin <= `SCURVE_HEADER;
            state <= ctrlHeader;
          end
        end
        ctrlHeader: begin
          UsbWrEn <= 1'b1;
          state <= ctrlSetChannel;
        end
        ctrlSetChannel: begin
          UsbWrEn <= 1'b0;
          ScParams.ctestChn <= ctestRun ? (64'd1 << chnCnt) : 64'd0;
          ScParams.discriMask <= MaskTop >> maskShift;
          // 'C' for one channel, 'c' for the full sweep
          UsbDin <= {singleRun ? 8'h43 : 8'h63, 2'b00, chnCnt};
          state <= ctrlWriteChannel;
        end
        ctrlWriteChannel: begin
          UsbWrEn <= 1'b1;
          state <= ctrlSetDac;
        end
        ////////////////////////////////////////////////////////////
        // One DAC step
        ////////////////////////////////////////////////////////////
        ctrlSetDac: begin
          UsbWrEn <= 1'b0;
          ScParams.dac10 <= reverseBits(dacCode);
          UsbDin <= {4'hD, 2'b00, dacCode};
          state <= ctrlWriteDac;
        end
        ctrlWriteDac: begin
          UsbWrEn <= 1'b1;
          state <= ctrlLoad;
        end
        ctrlLoad: begin
          UsbWrEn <= 1'b0;
          ScParamLoad <= 1'b1;
          state <= ctrlWaitLoad;
        end
        ctrlWaitLoad: begin
          ScParamLoad <= 1'b0;
          if (loadCnt == LoadW'(`SCURVE_LOAD_DELAY)) begin
            loadCnt <= '0;
            state <= ctrlStartTest;
          end else if (ConfigDone || loadCnt != '0) begin
            loadCnt <= loadCnt + 1'b1;   // Settling after config done
          end
        end
        ctrlStartTest: begin
          MeasureStart <= 1'b1;
          state <= ctrlWaitTest;
        end
        ctrlWaitTest: begin
          MeasureStart <= 1'b0;
          if (MeasureDone) state <= ctrlWaitData;
        end
        ctrlWaitData: begin
          UsbWrEn <= 1'b0;
          if (CountEmpty) begin
            state <= ctrlNextDac;
          end else begin
            CountRdEn <= 1'b1;
            state <= ctrlGetData;
          end
        end
        ctrlGetData: begin
          CountRdEn <= 1'b0;
          UsbDin <= CountWord;   // Still valid in the read cycle
          state <= ctrlPutData;
        end
        ctrlPutData: begin
          if (!UsbFull) begin
            UsbWrEn <= 1'b1;
            state <= ctrlWaitData;
          end
        end
        ////////////////////////////////////////////////////////////
        // Sweep bookkeeping and run end
        ////////////////////////////////////////////////////////////
        ctrlNextDac: begin
          if (dacCode == 10'(`SCURVE_LAST_DAC)) begin
            dacCode <= '0;
            state <= ctrlNextChannel;
          end else begin
            dacCode <= dacCode + 1'b1;
            state <= ctrlSetDac;
          end
        end
        ctrlNextChannel: begin
          if (singleRun || chnCnt == 6'd63) begin
            UsbDin <= `SCURVE_TRAILER;
            state <= ctrlTrailer;
          end else begin
            chnCnt <= chnCnt + 1'b1;
            state <= ctrlSetChannel;
          end
        end
        ctrlTrailer: begin
          UsbWrEn <= 1'b1;
          TestDone <= 1'b1;
          state <= ctrlDone;
        end
        ctrlDone: begin
          UsbWrEn <= 1'b0;
          if (TransmitDone) begin
            TestDone <= 1'b0;
            state <= ctrlIdle;
          end
        end
        default: state <= ctrlIdle;
      endcase
    end
  end

endmodule

// File: usbWordFifo.sv
`timescale 1ns/1ns
`include "scurve_cfg.svh"

module usbWordFifo (
  input  logic        Clk,
  input  logic        reset_n,
  input  logic        WrEn,
  input  logic        RdEn,
  input  logic [15:0] Din,
  output logic [15:0] Dout,
  output logic        Full,
  output logic        Empty
);

  localparam int Depth = `SCURVE_FIFO_DEPTH;
  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [15:0] mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] fill;
  logic doWr;
  logic doRd;

  assign Full = (fill == CntW'(Depth));
  assign Empty = (fill == '0);
  assign doWr = WrEn && !Full;    // Overflow dropped
  assign doRd = RdEn && !Empty;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
    end else begin
      if (doWr) wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (doRd) rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      case ({doWr, doRd})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: fill <= fill;   // Both or neither
      endcase
    end
  end

  // Storage and read data path
  always_ff @(posedge Clk) begin
    if (doWr) mem[wrPtr] <= Din;
    if (doRd) Dout <= mem[rdPtr];
  end

endmodule

// File: scurveTop.sv
`timescale 1ns/1ns

module scurveTop (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 TestStart,
  input  scurvePkg::runConfigT RunConfig,
  input  logic                 ConfigDone,
  input  logic                 Trigger,
  input  logic                 TransmitDone,
  input  logic                 UsbRdEn,
  output scurvePkg::scParamsT  ScParams,
  output logic                 ScParamLoad,
  output logic                 Inject,
  output logic [15:0]          UsbDout,
  output logic                 UsbEmpty,
  output logic                 TestDone
);

  // Counter to controller
  logic measureStart;
  logic measureDone;
  logic countEmpty;
  logic countRdEn;
  logic [15:0] countWord;

  // Controller to USB FIFO
  logic usbWrEn;
  logic usbFull;
  logic [15:0] usbDin;

  triggerCounter counter (
    .Clk(Clk),
    .reset_n(reset_n),
    .MeasureStart(measureStart),
    .Trigger(Trigger),
    .CountRdEn(countRdEn),
    .Inject(Inject),
    .MeasureDone(measureDone),
    .CountEmpty(countEmpty),
    .CountWord(countWord)
  );

  scurveTestControl control (
    .Clk(Clk),
    .reset_n(reset_n),
    .TestStart(TestStart),
    .RunConfig(RunConfig),
    .ConfigDone(ConfigDone),
    .MeasureDone(measureDone),
    .CountEmpty(countEmpty),
    .UsbFull(usbFull),
    .TransmitDone(TransmitDone),
    .CountWord(countWord),
    .ScParams(ScParams),
    .ScParamLoad(ScParamLoad),
    .MeasureStart(measureStart),
    .CountRdEn(countRdEn),
    .UsbWrEn(usbWrEn),
    .TestDone(TestDone),
    .UsbDin(usbDin)
  );

  usbWordFifo usbFifo (
    .Clk(Clk),
    .reset_n(reset_n),
    .WrEn(usbWrEn),
    .RdEn(UsbRdEn),
    .Din(usbDin),
    .Dout(UsbDout),
    .Full(usbFull),
    .Empty(UsbEmpty)
  );

endmodule

// File: scurveTb.sv
`timescale 1ns/1ns
`include "scurve_cfg.svh"

module scurveTb;
  import scurvePkg::*;

  localparam int Steps = `SCURVE_LAST_DAC + 1;
  localparam int StepCycles = 30 + `SCURVE_LOAD_DELAY + `SCURVE_PULSES * (`SCURVE_LISTEN + 1);

  logic Clk;
  logic reset_n;
  logic TestStart;
  runConfigT RunConfig;
  logic ConfigDone = 1'b0;
  logic Trigger = 1'b0;
  logic TransmitDone;
  logic UsbRdEn = 1'b0;
  scParamsT ScParams;
  logic ScParamLoad;
  logic Inject;
  logic [15:0] UsbDout;
  logic UsbEmpty;
  logic TestDone;

  // One entry per trace line
  runConfigT runCfgs[$];
  logic [31:0] runHits[$];

  // Expected responses of the run in progress
  logic [15:0] expWords[$];
  scParamsT expParams[$];
  int measHits[$];

  int limitCycles = 0;
  int readRate = 2;         // Host reads on readRate of 4 cycles
  int cfgWait = 0;          // ConfigDone goes out when this is 1
  int trigLeft = 0;
  int pulseNum = 0;         // Injection index inside a measurement
  int curHits = 0;
  bit readPending = 1'b0;   // Read strobe accepted at the coming edge

  scurveTop uut (
    .Clk(Clk),
    .reset_n(reset_n),
    .TestStart(TestStart),
    .RunConfig(RunConfig),
    .ConfigDone(ConfigDone),
    .Trigger(Trigger),
    .TransmitDone(TransmitDone),
    .UsbRdEn(UsbRdEn),
    .ScParams(ScParams),
    .ScParamLoad(ScParamLoad),
    .Inject(Inject),
    .UsbDout(UsbDout),
    .UsbEmpty(UsbEmpty),
    .TestDone(TestDone)
  );

  initial begin
    Clk = 1'b0;
    forever #50 Clk = ~Clk;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////
  task automatic endInFailure();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic stopWithError(input string msg);
    $display("ERROR: %s", msg);
    endInFailure();
  endtask

  task automatic checkWord(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      endInFailure();
    end
  endtask

  task automatic checkDone(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      endInFailure();
    end
  endtask

  task automatic checkParams(input string name, input scParamsT got, input scParamsT exp);
    if (got.ctestChn !== exp.ctestChn) begin
      $display("FAIL %s.ctestChn: got %h, expected %h", name, got.ctestChn, exp.ctestChn);
      endInFailure();
    end else if (got.dac10 !== exp.dac10) begin
      $display("FAIL %s.dac10: got %h, expected %h", name, got.dac10, exp.dac10);
      endInFailure();
    end else if (got.discriMask !== exp.discriMask) begin
      $display("FAIL %s.discriMask: got %h, expected %h", name, got.discriMask,
               exp.discriMask);
      endInFailure();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////////////////////////
  function automatic scParamsT idleParams();
    scParamsT p;
    p.ctestChn = '0;
    p.dac10 = '0;
    p.discriMask = '1;
    return p;
  endfunction

  function automatic scParamsT stepParams(input logic [5:0] chn, input logic [9:0] code,
                                          input logic ctest);
    scParamsT p;
    p.ctestChn = '0;
    if (ctest) p.ctestChn[chn] = 1'b1;
    p.dac10 = {<<{code}};   // LSB of the code lands in bit 9
    p.discriMask = '0;
    for (int j = 0; j < 3; j++) begin
      p.discriMask[191 - 3 * int'(chn) - j] = 1'b1;
    end
    return p;
  endfunction

  task automatic buildExpected(input runConfigT cfg, input logic [31:0] digits);
    int nChn;
    int hits;
    logic [5:0] chn;
    logic [7:0] tag;
    nChn = cfg.singleChn ? 1 : 64;
    tag = cfg.singleChn ? 8'h43 : 8'h63;
    expWords.push_back(`SCURVE_HEADER);
    for (int k = 0; k < nChn; k++) begin
      chn = cfg.singleChn ? cfg.testChn : 6'(k);
      expWords.push_back({tag, 2'b00, chn});
      for (int code = 0; code < Steps; code++) begin
        if (cfg.singleChn) hits = int'(digits[4 * (Steps - 1 - code) +: 4]);
        else hits = int'($urandom % 32'(`SCURVE_PULSES + 1));
        expWords.push_back({4'hD, 2'b00, 10'(code)});
        expWords.push_back(16'(hits));
        measHits.push_back(hits);
        expParams.push_back(stepParams(chn, 10'(code), cfg.ctestSel));
      end
    end
    expWords.push_back(`SCURVE_TRAILER);
  endtask

  task automatic readTrace();
    int fd;
    int n;
    int sc;
    int ch;
    int cs;
    logic [31:0] digits;
    string line;
    runConfigT cfg;
    fd = $fopen("scurve_trace.txt", "r");
    if (fd == 0) begin
      stopWithError("cannot open scurve_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#" && line[0] != 8'h0a) begin
          if ($sscanf(line, "%d %d %d %h", sc, ch, cs, digits) != 4) begin
            stopWithError({"malformed trace line: ", line});
          end
          cfg.singleChn = sc[0];
          cfg.testChn = ch[5:0];
          cfg.ctestSel = cs[0];
          for (int c = 0; c < Steps; c++) begin
            if (cfg.singleChn && digits[4 * c +: 4] > 4'(`SCURVE_PULSES))
              stopWithError("a trace hit count exceeds the number of injection pulses");
          end
          runCfgs.push_back(cfg);
          runHits.push_back(digits);
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Slow-control loader, injection response and host
  ////////////////////////////////////////////////////////////
  always @(negedge Clk) begin : stimMonitor
    if (reset_n && ScParamLoad) begin
      if (expParams.size() == 0) begin
        stopWithError("ScParamLoad pulsed with no DAC step left in the run");
      end else begin
        checkParams("ScParams", ScParams, expParams.pop_front());
        cfgWait = 1 + int'($urandom % 32'd5);   // Loader answers 1 to 5 cycles later
      end
    end else if (cfgWait > 0) begin
      cfgWait = cfgWait - 1;
    end
    if (reset_n && Inject) begin
      if (pulseNum == 0 && measHits.size() == 0) begin
        stopWithError("injection pulse with no measurement left in the run");
      end else begin
        if (pulseNum == 0) curHits = measHits.pop_front();
        if (pulseNum < curHits) trigLeft = `SCURVE_LISTEN;   // Whole window high
        pulseNum = (pulseNum + 1) % `SCURVE_PULSES;
      end
    end else if (trigLeft > 0) begin
      trigLeft = trigLeft - 1;
    end
  end

  always @(posedge Clk) begin : inputDrive
    ConfigDone <= (cfgWait == 1);
    Trigger <= (trigLeft > 0);
    UsbRdEn <= reset_n && (($urandom % 32'd4) < 32'(readRate));
  end

  // Host side of the USB FIFO
  always @(negedge Clk) begin : wordMonitor
    logic [15:0] expWord;
    if (reset_n) begin
      if (readPending && expWords.size() == 0) begin
        stopWithError("the host read a word from the USB FIFO when none was expected");
      end else if (readPending) begin
        expWord = expWords.pop_front();
        checkWord("UsbDout", UsbDout, expWord);
        if (expWords.size() == 0) checkDone("TestDone", TestDone, 1'b1);   // Trailer
      end
      readPending = UsbRdEn && !UsbEmpty;
    end
  end

  initial begin : watchdog
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge Clk);
    $display("ERROR: timeout, the scan runs did not finish within %0d cycles", limitCycles);
    endInFailure();
  end

  ////////////////////////////////////////////////////////////
  // Run sequence
  ////////////////////////////////////////////////////////////
  task automatic runScan(input int idx);
    int holdCycles;
    buildExpected(runCfgs[idx], runHits[idx]);
    readRate = 1 + idx % 3;   // 1 is the slow host
    holdCycles = 1 + int'($urandom % 32'd8);
    @(posedge Clk);
    RunConfig <= runCfgs[idx];
    TestStart <= 1'b1;
    @(posedge Clk);
    TestStart <= 1'b0;
    RunConfig <= '0;   // Must have been latched
    @(negedge Clk);
    checkDone("TestDone", TestDone, 1'b0);
    while (expWords.size() != 0) @(negedge Clk);
    @(negedge Clk);
    if (expParams.size() != 0 || measHits.size() != 0)
      stopWithError("the run ended before every DAC step was measured");
    checkDone("UsbEmpty", UsbEmpty, 1'b1);
    repeat (holdCycles) begin
      @(negedge Clk);
      checkDone("TestDone", TestDone, 1'b1);
    end
    @(posedge Clk);
    TransmitDone <= 1'b1;
    @(posedge Clk);
    TransmitDone <= 1'b0;
    @(negedge Clk);
    checkDone("TestDone", TestDone, 1'b0);
    @(negedge Clk);
    checkParams("ScParams", ScParams, idleParams());
  endtask

  initial begin : mainSequence
    int total;
    void'($urandom(32'h7fc1_0a8d));
    reset_n = 1'b0;
    TestStart = 1'b0;
    RunConfig = '0;
    TransmitDone = 1'b0;
    readTrace();
    total = 0;
    foreach (runCfgs[i]) begin
      total += 100 + (runCfgs[i].singleChn ? 1 : 64) * (10 + Steps * StepCycles);
    end
    limitCycles = 2 * total + 216;   // Margin over the nominal run length
    repeat (16) @(posedge Clk);
    reset_n <= 1'b1;
    @(negedge Clk);
    checkDone("UsbEmpty", UsbEmpty, 1'b1);
    checkDone("TestDone", TestDone, 1'b0);
    checkParams("ScParams", ScParams, idleParams());
    for (int i = 0; i < runCfgs.size(); i++) begin
      runScan(i);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+.
scurvePkg.sv
triggerCounter.sv
scurveTestControl.sv
usbWordFifo.sv
scurveTop.sv
scurveTb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the S-curve scan testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module scurveTb -o scurveSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/scurveSim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0

// File: scurve_trace.txt
# singleChn testChn ctestSel hits
# hits: one hex digit per DAC code, code 0 first, ignored for 64-channel runs
1 5 1 0362
1 40 0 6610
0 0 1 0000
1 63 1 4056
1 0 0 2222
0 0 0 0000
1 17 1 6543
1 32 0 0123
